/* logic/int_div_pkg.sv */
// shared types and constants for the iterative divide unit
// compile first; modules pull these in by import or scoped name

package int_div_pkg;

  // ------------------------------
  // request function
  // ------------------------------

  // selects how the operands are read
  // unsigned treats a and b as plain magnitudes
  // signed takes magnitudes on load and fixes signs at the output
  typedef enum logic {
    DIV_FN_UNSIGNED = 1'b0,
    DIV_FN_SIGNED   = 1'b1
  } div_fn_e;

  // ------------------------------
  // control FSM states
  // ------------------------------

  // idle waits for a request, calc runs one quotient bit per cycle,
  // done holds the result until the response is taken
  typedef enum logic [1:0] {
    DIV_IDLE = 2'd0,
    DIV_CALC = 2'd1,
    DIV_DONE = 2'd2
  } div_state_e;

  // ------------------------------
  // sizing
  // ------------------------------

  // operand width used when the top is not overridden
  // result word is twice this, remainder on top
  localparam int DIV_W_DEFAULT = 32;

endpackage

/* logic/int_div_ctrl_if.sv */
// control and status lines between the divide FSM and its datapath
// instantiate once in the top and hand each side its modport

interface int_div_ctrl_if #(
  parameter int DIV_W = int_div_pkg::DIV_W_DEFAULT
);

  // counter runs from DIV_W-1 down to zero
  localparam int CNT_W = $clog2(DIV_W);

  // ------------------------------
  // control to datapath
  // ------------------------------

  // take operands, signs and counter start on this edge
  logic load;
  // perform one shift-subtract step on this edge
  logic iterate;

  // ------------------------------
  // datapath to control
  // ------------------------------

  // iteration counter has reached zero
  logic count_zero;
  // trial subtraction went negative, the step restores
  logic sub_neg;
  // live iteration counter, written by the datapath
  logic [CNT_W-1:0] count;

  // FSM side only needs the end-of-loop flag
  modport control (
    output load,
    output iterate,
    input  count_zero
  );

  // datapath owns the counter and the step decision
  modport dpath (
    input  load,
    input  iterate,
    output count_zero,
    output sub_neg,
    output count
  );

endinterface

/* logic/int_div_ctrl.sv */
// control FSM of the divide unit
// owns the val/rdy handshake on both sides and steers the datapath

module int_div_ctrl (
  input  logic            clk,
  input  logic            reset,

  // request side handshake
  input  logic            req_val,
  output logic            req_rdy,

  // response side handshake
  output logic            resp_val,
  input  logic            resp_rdy,

  int_div_ctrl_if.control ctl
);

  import int_div_pkg::*;

  // ------------------------------
  // state register
  // ------------------------------

  div_state_e state;
  div_state_e state_next;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= DIV_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // ------------------------------
  // transfers
  // ------------------------------

  logic req_go;
  logic resp_go;

  // request taken on an edge with both high
  assign req_go  = req_val && req_rdy;
  // response taken the same way
  assign resp_go = resp_val && resp_rdy;

  // ------------------------------
  // next state
  // ------------------------------

  // timeline from the accepting edge:
  // DIV_W calc edges follow, one quotient bit each, and the last one
  // (counter at zero) also moves to done, so resp_val is high after the
  // DIV_W+1-th edge counting the accepting edge itself
  always_comb begin
    state_next = state;
    case (state)
      DIV_IDLE: begin
        if (req_go) begin
          state_next = DIV_CALC;
        end
      end
      DIV_CALC: begin
        // counter at zero means this edge produces the final bit
        if (ctl.count_zero) begin
          state_next = DIV_DONE;
        end
      end
      DIV_DONE: begin
        // hold here with the result frozen until the sink takes it
        if (resp_go) begin
          state_next = DIV_IDLE;
        end
      end
      default: begin
        state_next = DIV_IDLE;
      end
    endcase
  end

  // ------------------------------
  // outputs
  // ------------------------------

  // one operation at a time, so only idle accepts
  assign req_rdy  = (state == DIV_IDLE);
  assign resp_val = (state == DIV_DONE);

  // operands latch on the accepting edge
  assign ctl.load    = req_go;
  // step every cycle of calc, including the exit edge
  assign ctl.iterate = (state == DIV_CALC);

endmodule

/* logic/int_div_dpath.sv */
// restoring shift-subtract datapath of the divide unit
// loads operand magnitudes, steps one quotient bit per iterate, signs the result

module int_div_dpath #(
  parameter int DIV_W = int_div_pkg::DIV_W_DEFAULT
) (
  input  logic                  clk,
  input  logic                  reset,

  // request payload, sampled on load
  input  int_div_pkg::div_fn_e  req_fn,
  input  logic [DIV_W-1:0]      req_a,
  input  logic [DIV_W-1:0]      req_b,

  // remainder in the upper half, quotient in the lower half
  output logic [2*DIV_W-1:0]    resp_result,

  int_div_ctrl_if.dpath         ctl
);

  import int_div_pkg::*;

  // counter width and the combined remainder/quotient register width
  localparam int CNT_W = $clog2(DIV_W);
  localparam int RQ_W  = 2 * DIV_W + 1;

  // ------------------------------
  // state
  // ------------------------------

  // upper DIV_W+1 bits hold the partial remainder,
  // lower DIV_W bits start as the dividend and fill with quotient bits
  logic [RQ_W-1:0]  rq;
  // divisor magnitude aligned with the remainder field
  logic [RQ_W-1:0]  div_sh;

  // sign and corner flags captured with the operands
  logic             quot_neg;
  logic             rem_neg;
  logic             div_zero;

  // ------------------------------
  // operand conditioning
  // ------------------------------

  logic             is_signed;
  logic [DIV_W-1:0] a_mag;
  logic [DIV_W-1:0] b_mag;

  assign is_signed = (req_fn == DIV_FN_SIGNED);

  // magnitudes only differ from the raw operands in signed mode
  // most negative value maps to itself, read as unsigned that is correct
  assign a_mag = (is_signed && req_a[DIV_W-1]) ? -req_a : req_a;
  assign b_mag = (is_signed && req_b[DIV_W-1]) ? -req_b : req_b;

  // ------------------------------
  // shift-subtract step
  // ------------------------------

  logic [RQ_W-1:0]  shifted;
  logic [RQ_W-1:0]  diff;
  logic [RQ_W-1:0]  step;

  // bring the next dividend bit into the remainder
  assign shifted = rq << 1;
  assign diff    = shifted - div_sh;

  // top bit of the difference is the borrow
  assign ctl.sub_neg = diff[RQ_W-1];

  // on a borrow keep the shifted value, whose low bit is already a zero quotient bit
  // otherwise take the difference and set the quotient bit
  assign step = ctl.sub_neg ? shifted : {diff[RQ_W-1:1], 1'b1};

  // operands and sign flags taken on load, remainder and quotient stepped on iterate
  always_ff @(posedge clk) begin
    if (ctl.load) begin
      rq       <= {{(DIV_W + 1){1'b0}}, a_mag};
      div_sh   <= {1'b0, b_mag, {DIV_W{1'b0}}};
      quot_neg <= is_signed && (req_a[DIV_W-1] ^ req_b[DIV_W-1]);
      rem_neg  <= is_signed && req_a[DIV_W-1];
      div_zero <= (req_b == '0);
    end else if (ctl.iterate) begin
      rq <= step;
    end
  end

  // ------------------------------
  // iteration counter
  // ------------------------------

  // one count per quotient bit, the step taken at zero is the last one
  always_ff @(posedge clk) begin
    if (reset) begin
      ctl.count <= '0;
    end else if (ctl.load) begin
      ctl.count <= CNT_W'(DIV_W - 1);
    end else if (ctl.iterate) begin
      ctl.count <= ctl.count - 1'b1;
    end
  end

  assign ctl.count_zero = (ctl.count == '0);

  // ------------------------------
  // output stage
  // ------------------------------

  logic [DIV_W-1:0] quot_mag;
  logic [DIV_W-1:0] rem_mag;
  logic [DIV_W-1:0] quot_out;
  logic [DIV_W-1:0] rem_out;

  // remainder is below the divisor so bit 2*DIV_W is always clear here
  assign quot_mag = rq[DIV_W-1:0];
  assign rem_mag  = rq[2*DIV_W-1:DIV_W];

  // divide by zero forces all ones; the remainder already comes out as
  // the dividend since nothing was ever subtracted
  assign quot_out = div_zero ? '1 : (quot_neg ? -quot_mag : quot_mag);

  // remainder follows the dividend sign
  assign rem_out  = rem_neg ? -rem_mag : rem_mag;

  assign resp_result = {rem_out, quot_out};

endmodule

/* logic/int_div_unit.sv */
// top level of the iterative divide unit
// val/rdy request in, one response word out with remainder over quotient

module int_div_unit #(
  parameter int DIV_W = int_div_pkg::DIV_W_DEFAULT
) (
  input  logic                 clk,
  input  logic                 reset,

  // ------------------------------
  // request side
  // ------------------------------
  input  logic                 req_val,
  output logic                 req_rdy,
  input  int_div_pkg::div_fn_e req_fn,
  input  logic [DIV_W-1:0]     req_a,
  input  logic [DIV_W-1:0]     req_b,

  // ------------------------------
  // response side
  // ------------------------------
  output logic                 resp_val,
  input  logic                 resp_rdy,
  output logic [2*DIV_W-1:0]   resp_result
);

  // load/iterate down, counter status and step sign up
  int_div_ctrl_if #(
    .DIV_W (DIV_W)
  ) ctl_if ();

  // handshake and sequencing
  int_div_ctrl u_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .ctl      (ctl_if.control)
  );

  // operands, iteration and signed result
  // payload lines bypass the FSM, transfers are decided in u_ctrl
  int_div_dpath #(
    .DIV_W (DIV_W)
  ) u_dpath (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_result (resp_result),
    .ctl         (ctl_if.dpath)
  );

endmodule

/* verif/int_div_asserts.sv */
// handshake checks for the divide unit
// bound into int_div_unit, sees its ports and the FSM state register

module int_div_asserts #(
  parameter int DIV_W = int_div_pkg::DIV_W_DEFAULT
) (
  input logic                    clk,
  input logic                    reset,
  input logic                    req_rdy,
  input logic                    resp_val,
  input logic                    resp_rdy,
  input logic [2*DIV_W-1:0]      resp_result,
  input int_div_pkg::div_state_e state
);

  timeunit 1ns;
  timeprecision 100ps;

  import int_div_pkg::*;

  // ------------------------------
  // handshake
  // ------------------------------

  // only idle accepts and only done offers a response
  a_rdy_val_excl: assert property (
    @(posedge clk) disable iff (reset) !(req_rdy && resp_val)
  ) else $error("req_rdy and resp_val high in the same cycle");

  // a waiting response keeps its valid and its payload
  a_resp_hold: assert property (
    @(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_result))
  ) else $error("response changed while resp_rdy was low");

  // first edge after reset release must see the unit ready
  a_rdy_after_reset: assert property (
    @(posedge clk) $fell(reset) |-> req_rdy
  ) else $error("req_rdy low in the first cycle after reset");

  // ------------------------------
  // FSM timing
  // ------------------------------

  // ready drops on the accepting edge, done follows DIV_W edges later
  a_calc_len: assert property (
    @(posedge clk) disable iff (reset)
    $fell(req_rdy) |-> ##DIV_W (state == DIV_DONE)
  ) else $error("calc did not end in done after DIV_W cycles");

endmodule

// attach to every instance of the top level
bind int_div_unit int_div_asserts #(
  .DIV_W (DIV_W)
) u_asserts (
  .clk         (clk),
  .reset       (reset),
  .req_rdy     (req_rdy),
  .resp_val    (resp_val),
  .resp_rdy    (resp_rdy),
  .resp_result (resp_result),
  .state       (u_ctrl.state)
);

/* verif/int_div_tb.sv */
// testbench for the iterative divide unit
// runs a fixed table, then random operations, each with back-pressure on the response

module int_div_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import int_div_pkg::*;

  localparam int DIV_W   = DIV_W_DEFAULT;
  localparam int RES_W   = 2 * DIV_W;
  localparam int TIMEOUT = 4 * DIV_W + 20;
  localparam int N_RAND  = 200;
  localparam logic [DIV_W-1:0] MIN_VAL = {1'b1, {(DIV_W - 1){1'b0}}};

  // one table row: function, operands, expected quotient and remainder
  typedef struct packed {
    div_fn_e          fn;
    logic [DIV_W-1:0] a;
    logic [DIV_W-1:0] b;
    logic [DIV_W-1:0] q;
    logic [DIV_W-1:0] r;
  } row_t;

  logic             clk;
  logic             reset;
  logic             req_val;
  logic             req_rdy;
  div_fn_e          req_fn;
  logic [DIV_W-1:0] req_a;
  logic [DIV_W-1:0] req_b;
  logic             resp_val;
  logic             resp_rdy;
  logic [RES_W-1:0] resp_result;

  row_t        rows[$];
  int          tests_run;
  int          tests_failed;
  int          test_errs;
  bit          aborted;

  int_div_unit #(
    .DIV_W (DIV_W)
  ) u_dut (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // ------------------------------
  // helpers
  // ------------------------------

  task automatic report_mismatch(input string name, input logic [RES_W-1:0] got,
                                 input logic [RES_W-1:0] exp);
    $display("** Error at %0t: %s got %h, expected %h", $time, name, got, exp);
    test_errs++;
  endtask

  task automatic finish_test(input string label);
    tests_run++;
    if (test_errs == 0) begin
      $display("%s: ok", label);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", label, test_errs);
    end
  endtask

  task automatic add_row(input div_fn_e fn, input logic [DIV_W-1:0] a, input logic [DIV_W-1:0] b,
                         input logic [DIV_W-1:0] q, input logic [DIV_W-1:0] r);
    rows.push_back('{fn, a, b, q, r});
  endtask

  // reference model, remainder over quotient, built from the division rules
  function automatic logic [RES_W-1:0] expected_result(input div_fn_e fn,
                                                       input logic [DIV_W-1:0] a,
                                                       input logic [DIV_W-1:0] b);
    logic             a_neg;
    logic             b_neg;
    logic [DIV_W-1:0] a_abs;
    logic [DIV_W-1:0] b_abs;
    logic [DIV_W-1:0] q;
    logic [DIV_W-1:0] r;
    a_neg = (fn == DIV_FN_SIGNED) && a[DIV_W-1];
    b_neg = (fn == DIV_FN_SIGNED) && b[DIV_W-1];
    a_abs = a_neg ? -a : a;
    b_abs = b_neg ? -b : b;
    if (b == '0) begin
      q = '1;
      r = a;
    end else if (fn == DIV_FN_SIGNED && a == MIN_VAL && b == '1) begin
      q = MIN_VAL;
      r = '0;
    end else begin
      q = a_abs / b_abs;
      r = a_abs % b_abs;
      // quotient negative on differing signs, remainder follows the dividend
      if (a_neg ^ b_neg) begin
        q = -q;
      end
      if (a_neg) begin
        r = -r;
      end
    end
    return {r, q};
  endfunction

  // ------------------------------
  // one operation with latency and back-pressure checks
  // ------------------------------

  task automatic run_op(input div_fn_e fn, input logic [DIV_W-1:0] a, input logic [DIV_W-1:0] b,
                        input logic [RES_W-1:0] exp_res, input string label);
    int               cycles;
    int               edges;
    int               hold;
    logic [RES_W-1:0] held;
    test_errs = 0;
    cycles = 0;
    while (!req_rdy && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!req_rdy) begin
      $display("%s: timed out waiting for req_rdy", label);
      test_errs++;
      finish_test(label);
      aborted = 1;
      return;
    end
    req_val = 1'b1;
    req_fn  = fn;
    req_a   = a;
    req_b   = b;
    // ready was high at the falling edge, so this edge accepts
    @(posedge clk);
    edges = 1;
    @(negedge clk);
    req_val = 1'b0;
    while (!resp_val && edges < TIMEOUT) begin
      if (req_rdy) begin
        report_mismatch("req_rdy", req_rdy, 1'b0);
      end
      @(posedge clk);
      edges++;
      @(negedge clk);
    end
    if (!resp_val) begin
      $display("%s: timed out waiting for resp_val", label);
      test_errs++;
      finish_test(label);
      aborted = 1;
      return;
    end
    // edges counted include the accepting one
    if (edges != DIV_W + 1) begin
      report_mismatch("latency in edges", edges, DIV_W + 1);
    end
    if (resp_result[DIV_W-1:0] !== exp_res[DIV_W-1:0]) begin
      report_mismatch("resp_result quotient", resp_result[DIV_W-1:0], exp_res[DIV_W-1:0]);
    end
    if (resp_result[RES_W-1:DIV_W] !== exp_res[RES_W-1:DIV_W]) begin
      report_mismatch("resp_result remainder", resp_result[RES_W-1:DIV_W],
                      exp_res[RES_W-1:DIV_W]);
    end
    // sink stalls, result must stay frozen
    held = resp_result;
    hold = $urandom % 20 + 1;
    for (int k = 0; k < hold; k++) begin
      @(negedge clk);
      if (!resp_val) begin
        report_mismatch("resp_val", resp_val, 1'b1);
      end
      if (resp_result !== held) begin
        report_mismatch("resp_result", resp_result, held);
      end
      if (req_rdy) begin
        report_mismatch("req_rdy", req_rdy, 1'b0);
      end
    end
    resp_rdy = 1'b1;
    @(posedge clk);
    @(negedge clk);
    resp_rdy = 1'b0;
    // back in idle right after the response is taken
    if (resp_val) begin
      report_mismatch("resp_val", resp_val, 1'b0);
    end
    if (!req_rdy) begin
      report_mismatch("req_rdy", req_rdy, 1'b1);
    end
    finish_test(label);
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------

  initial begin
    logic [DIV_W-1:0] a;
    logic [DIV_W-1:0] b;
    div_fn_e          fn;
    int               sel;
    void'($urandom(32'h60f44cb2));
    tests_run    = 0;
    tests_failed = 0;
    aborted      = 1'b0;
    clk      = 1'b0;
    reset    = 1'b1;
    req_val  = 1'b0;
    req_fn   = DIV_FN_UNSIGNED;
    req_a    = '0;
    req_b    = '0;
    resp_rdy = 1'b0;

    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    test_errs = 0;
    if (!req_rdy) begin
      report_mismatch("req_rdy", req_rdy, 1'b1);
    end
    if (resp_val) begin
      report_mismatch("resp_val", resp_val, 1'b0);
    end
    finish_test("reset state");

    // unsigned, including divisor above dividend and all-ones dividend
    add_row(DIV_FN_UNSIGNED, 32'd100, 32'd7, 32'd14, 32'd2);
    add_row(DIV_FN_UNSIGNED, 32'd5, 32'd9, 32'd0, 32'd5);
    add_row(DIV_FN_UNSIGNED, 32'hffffffff, 32'd1, 32'hffffffff, 32'd0);
    add_row(DIV_FN_UNSIGNED, 32'hffffffff, 32'h10, 32'h0fffffff, 32'hf);
    add_row(DIV_FN_UNSIGNED, 32'd0, 32'd3, 32'd0, 32'd0);
    add_row(DIV_FN_UNSIGNED, 32'h80000000, 32'hffffffff, 32'd0, 32'h80000000);
    // signed, all four sign combinations
    add_row(DIV_FN_SIGNED, 32'd7, 32'd2, 32'd3, 32'd1);
    add_row(DIV_FN_SIGNED, 32'hfffffff9, 32'd2, 32'hfffffffd, 32'hffffffff);
    add_row(DIV_FN_SIGNED, 32'd7, 32'hfffffffe, 32'hfffffffd, 32'd1);
    add_row(DIV_FN_SIGNED, 32'hfffffff9, 32'hfffffffe, 32'd3, 32'hffffffff);
    add_row(DIV_FN_SIGNED, 32'hffffff9c, 32'd7, 32'hfffffff2, 32'hfffffffe);
    // divide by zero and the most negative value
    add_row(DIV_FN_UNSIGNED, 32'd1234, 32'd0, 32'hffffffff, 32'd1234);
    add_row(DIV_FN_SIGNED, 32'hfffffffb, 32'd0, 32'hffffffff, 32'hfffffffb);
    add_row(DIV_FN_SIGNED, 32'h80000000, 32'hffffffff, 32'h80000000, 32'd0);
    add_row(DIV_FN_SIGNED, 32'h80000000, 32'd1, 32'h80000000, 32'd0);
    add_row(DIV_FN_SIGNED, 32'h80000000, 32'd2, 32'hc0000000, 32'd0);

    foreach (rows[i]) begin
      if (!aborted) begin
        run_op(rows[i].fn, rows[i].a, rows[i].b, {rows[i].r, rows[i].q},
               $sformatf("table row %0d", i));
      end
    end

    // random operands, biased toward zero, minus one and small divisors
    for (int i = 0; i < N_RAND; i++) begin
      if (!aborted) begin
        fn  = ($urandom % 2 == 0) ? DIV_FN_UNSIGNED : DIV_FN_SIGNED;
        a   = ($urandom % 8 == 0) ? MIN_VAL : $urandom;
        sel = $urandom % 8;
        if (sel == 0) begin
          b = '0;
        end else if (sel == 1) begin
          b = '1;
        end else if (sel < 4) begin
          b = $urandom % 256;
        end else begin
          b = $urandom;
        end
        run_op(fn, a, b, expected_result(fn, a, b), $sformatf("random op %0d", i));
      end
    end

    $display("%0d tests run, %0d failed", tests_run, tests_failed);
    if (tests_failed == 0 && !aborted) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* int_div.f */
logic/int_div_pkg.sv
logic/int_div_ctrl_if.sv
logic/int_div_ctrl.sv
logic/int_div_dpath.sv
logic/int_div_unit.sv
verif/int_div_asserts.sv
verif/int_div_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the divide unit testbench with Verilator
# the result is read from the log

LOG=sim.log
rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal --top-module int_div_tb \
  -f int_div.f -o int_div_sim > "$LOG" 2>&1 \
  && ./obj_dir/int_div_sim >> "$LOG" 2>&1 \
  || echo "build or simulation stopped with an error" >> "$LOG"

cat "$LOG"

grep -q "Some tests failed" "$LOG" && { echo "FAIL"; exit 1; }
grep -q "All tests passed" "$LOG" && { echo "PASS"; exit 0; } || { echo "FAIL"; exit 1; }
